/* hw/mpmp_pkg.sv */
// sizes, widths and data types shared by the multi-push multi-pop FIFO and its testbench
package mpmp_pkg;

    // width of one data word
    localparam int DATA_WIDTH = 32;

    // number of words the FIFO promises to hold
    localparam int FIFO_DEPTH = 19;

    // largest burst in one push or pop, which is also the number of banks
    localparam int MAX_BURST = 13;

    // words per bank, rounded up so the banks together cover FIFO_DEPTH
    localparam int BANK_DEPTH = (FIFO_DEPTH + MAX_BURST - 1) / MAX_BURST;

    // a bank with a single word still gets a one-bit address
    localparam int BANK_ADDR_WIDTH = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1;

    // wide enough for the values 0 to MAX_BURST
    localparam int COUNT_WIDTH = $clog2(MAX_BURST + 1);

    // wide enough for the values 0 to FIFO_DEPTH
    localparam int OCCUPANCY_WIDTH = $clog2(FIFO_DEPTH + 1);

    // one data word
    typedef logic [DATA_WIDTH-1:0] data_word_t;

    // push, pop, can_push, can_pop and pop_resp counts
    typedef logic [COUNT_WIDTH-1:0] burst_count_t;

    // occupancy counter value of either tracker
    typedef logic [OCCUPANCY_WIDTH-1:0] occupancy_t;

    // one enable bit per bank, bit i drives bank i
    typedef logic [MAX_BURST-1:0] bank_mask_t;

    // index of a bank, always kept below MAX_BURST
    typedef logic [COUNT_WIDTH-1:0] bank_ptr_t;

    // MAX_BURST words side by side, lane 0 is the first word in FIFO order
    typedef logic [MAX_BURST-1:0][DATA_WIDTH-1:0] lane_data_t;

endpackage

/* hw/mpmp_occupancy_tracker.sv */
// occupancy tracker with all-or-nothing request check, word counter and registered burst limit
`timescale 1ns/1ps

module mpmp_occupancy_tracker #(
    parameter mpmp_pkg::occupancy_t RESET_WORDS = mpmp_pkg::FIFO_DEPTH // counter value in reset
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  mpmp_pkg::burst_count_t request,      // words asked for in this cycle
    input  logic                   landed,       // the opposite side finished a burst
    input  mpmp_pkg::burst_count_t landed_count, // size of that burst
    output logic                   accept,       // one-cycle strobe toward the steerer
    output mpmp_pkg::burst_count_t accept_count, // zero whenever the request was dropped
    output mpmp_pkg::burst_count_t limit         // can_push or can_pop
);
    import mpmp_pkg::*;

    occupancy_t   words;          // free words on the write side, stored words on the read side
    occupancy_t   words_next;
    logic         take;           // request passes every check
    burst_count_t take_count;
    logic         landed_r;       // landed strobe sampled one edge after it arrives
    burst_count_t landed_count_r;
    burst_count_t add_count;

    // a request is taken whole or not at all, and never for more than is counted
    assign take = (request != '0)
               && (request <= burst_count_t'(MAX_BURST))
               && (occupancy_t'(request) <= words);

    assign take_count = take ? request : '0;
    assign add_count  = landed_r ? landed_count_r : '0;

    // take_count never exceeds words, so the subtraction cannot wrap
    assign words_next = words - occupancy_t'(take_count) + occupancy_t'(add_count);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            words          <= RESET_WORDS;
            limit          <= '0;    // nothing is offered while in reset
            accept         <= 1'b0;
            accept_count   <= '0;
            landed_r       <= 1'b0;
            landed_count_r <= '0;
        end else begin
            words          <= words_next;
            accept         <= take;
            accept_count   <= take_count;
            landed_r       <= landed;
            landed_count_r <= landed_count;
            // the limit is the counter clipped to one burst
            if (words_next >= occupancy_t'(MAX_BURST)) begin
                limit <= burst_count_t'(MAX_BURST);
            end else begin
                limit <= words_next[COUNT_WIDTH-1:0];
            end
        end
    end

endmodule

/* hw/mpmp_bank_steer.sv */
// bank steerer turning an accepted count into a rotated bank mask with a rotating start pointer
`timescale 1ns/1ps

module mpmp_bank_steer (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   accept,       // strobe from the tracker
    input  mpmp_pkg::burst_count_t accept_count, // zero when nothing was accepted
    output mpmp_pkg::bank_mask_t   bank_mask,    // banks touched by the burst, after rotation
    output mpmp_pkg::bank_ptr_t    ptr,          // start bank of the burst in the first stage
    output logic                   landed,       // burst is being applied to the banks
    output mpmp_pkg::burst_count_t landed_count
);
    import mpmp_pkg::*;

    bank_mask_t                 low_mask;  // lowest accept_count bits set
    bank_mask_t                 mask_r;    // unrotated mask, first stage
    burst_count_t               count_r;
    logic                       accept_r;
    logic [COUNT_WIDTH:0]       ptr_sum;   // one extra bit so ptr plus a full burst fits
    bank_ptr_t                  ptr_next;
    logic [2*MAX_BURST-1:0]     mask_dbl;

    always_comb begin
        for (int i = 0; i < MAX_BURST; i++) begin
            low_mask[i] = (i < int'(accept_count));
        end
    end

    // the next burst starts right after the one now in the first stage
    assign ptr_sum  = {1'b0, ptr} + {1'b0, count_r};
    assign ptr_next = (ptr_sum >= (COUNT_WIDTH+1)'(MAX_BURST))
                    ? bank_ptr_t'(ptr_sum - (COUNT_WIDTH+1)'(MAX_BURST))
                    : bank_ptr_t'(ptr_sum);

    // doubling the mask turns a left shift into a rotation over MAX_BURST bits
    assign mask_dbl = {mask_r, mask_r} << ptr;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mask_r       <= '0;
            count_r      <= '0;
            accept_r     <= 1'b0;
            ptr          <= '0;
            bank_mask    <= '0;
            landed       <= 1'b0;
            landed_count <= '0;
        end else begin
            // first stage builds the mask and moves the pointer past the previous burst
            mask_r   <= low_mask;
            count_r  <= accept_count;
            accept_r <= accept;
            ptr      <= ptr_next; // count_r is zero without an accept, so ptr holds
            // second stage rotates the mask onto the banks
            bank_mask    <= mask_dbl[2*MAX_BURST-1:MAX_BURST];
            landed       <= accept_r;
            landed_count <= count_r;
        end
    end

endmodule

/* hw/mpmp_write_aligner.sv */
// write aligner delaying push data and rotating its lanes onto the banks
`timescale 1ns/1ps

module mpmp_write_aligner (
    input  logic                 clk,
    input  mpmp_pkg::lane_data_t push_data,  // sampled together with push
    input  mpmp_pkg::bank_ptr_t  ptr,        // start bank from the steerer first stage
    output mpmp_pkg::lane_data_t bank_wdata  // lane i goes to bank i
);
    import mpmp_pkg::*;

    lane_data_t                          data_d1;
    lane_data_t                          data_d2;  // lines up with the steerer first stage
    logic [2*MAX_BURST*DATA_WIDTH-1:0]   data_dbl;

    // word 0 has to land in bank ptr, so the lanes rotate left by ptr words
    assign data_dbl = {data_d2, data_d2} << (int'(ptr) * DATA_WIDTH);

    // payload only, the masks decide what is actually written
    always_ff @(posedge clk) begin
        data_d1    <= push_data;
        data_d2    <= data_d1;
        bank_wdata <= data_dbl[2*MAX_BURST*DATA_WIDTH-1:MAX_BURST*DATA_WIDTH];
    end

endmodule

/* hw/mpmp_ram_bank.sv */
// one narrow RAM bank with wrapping write and read addresses and a registered read
`timescale 1ns/1ps

module mpmp_ram_bank (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 write,  // store wdata at the write address
    input  mpmp_pkg::data_word_t wdata,
    input  logic                 read,   // take the word at the read address
    output mpmp_pkg::data_word_t rdata   // appears two edges after read
);
    import mpmp_pkg::*;

    data_word_t                 mem [BANK_DEPTH];
    logic [BANK_ADDR_WIDTH-1:0] waddr;
    logic [BANK_ADDR_WIDTH-1:0] raddr;
    logic [BANK_ADDR_WIDTH-1:0] raddr_q;  // address of the word being read out
    logic                       read_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            waddr   <= '0;
            raddr   <= '0;
            raddr_q <= '0;
            read_q  <= 1'b0;
        end else begin
            read_q <= read;
            if (write) begin
                waddr <= (waddr == BANK_ADDR_WIDTH'(BANK_DEPTH - 1)) ? '0 : waddr + 1'b1;
            end
            if (read) begin
                raddr_q <= raddr;
                raddr   <= (raddr == BANK_ADDR_WIDTH'(BANK_DEPTH - 1)) ? '0 : raddr + 1'b1;
            end
        end
    end

    // storage and read data have no reset
    always_ff @(posedge clk) begin
        if (write) begin
            mem[waddr] <= wdata;
        end
        if (read_q) begin
            rdata <= mem[raddr_q];
        end
    end

endmodule

/* hw/mpmp_read_aligner.sv */
// read aligner staging bank data, undoing the bank rotation and driving pop_data and pop_resp
`timescale 1ns/1ps

module mpmp_read_aligner (
    input  logic                   clk,
    input  logic                   reset_n,
    input  mpmp_pkg::lane_data_t   bank_rdata, // lane i comes from bank i
    input  mpmp_pkg::bank_ptr_t    ptr,        // start bank, one stage ahead of count
    input  mpmp_pkg::burst_count_t count,      // accepted pop count from the steerer
    output mpmp_pkg::lane_data_t   pop_data,
    output mpmp_pkg::burst_count_t pop_resp
);
    import mpmp_pkg::*;

    bank_ptr_t                         ptr_d0;   // now beside count
    bank_ptr_t                         ptr_d1;
    bank_ptr_t                         ptr_d2;
    bank_ptr_t                         ptr_s;
    burst_count_t                      count_d1;
    burst_count_t                      count_d2; // matches the two-edge bank read
    burst_count_t                      count_s;
    lane_data_t                        stage_data;
    logic [2*MAX_BURST*DATA_WIDTH-1:0] data_dbl;

    // bank ptr holds the oldest word, so rotating right by ptr puts it in lane 0
    assign data_dbl = {stage_data, stage_data} >> (int'(ptr_s) * DATA_WIDTH);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ptr_d0   <= '0;
            ptr_d1   <= '0;
            ptr_d2   <= '0;
            ptr_s    <= '0;
            count_d1 <= '0;
            count_d2 <= '0;
            count_s  <= '0;
            pop_resp <= '0;
        end else begin
            ptr_d0   <= ptr;
            ptr_d1   <= ptr_d0;
            ptr_d2   <= ptr_d1;
            ptr_s    <= ptr_d2;
            count_d1 <= count;
            count_d2 <= count_d1;
            count_s  <= count_d2;
            pop_resp <= count_s;  // zero in every cycle without a response
        end
    end

    always_ff @(posedge clk) begin
        stage_data <= bank_rdata;                      // cuts the path from the banks
        pop_data   <= data_dbl[MAX_BURST*DATA_WIDTH-1:0];
    end

endmodule

/* hw/multi_push_multi_pop_fifo.sv */
// multi-push multi-pop FIFO top level wiring trackers, steerers, aligners and the bank array
`timescale 1ns/1ps

module multi_push_multi_pop_fifo (
    input  logic                   clk,
    input  logic                   reset_n,
    input  mpmp_pkg::burst_count_t push,      // words offered this cycle
    input  mpmp_pkg::lane_data_t   push_data, // lane 0 is the oldest of the burst
    output mpmp_pkg::burst_count_t can_push,  // largest push taken right now
    input  mpmp_pkg::burst_count_t pop,       // words requested this cycle
    output mpmp_pkg::lane_data_t   pop_data,  // valid only while pop_resp is nonzero
    output mpmp_pkg::burst_count_t pop_resp,  // accepted pop count, six cycles later
    output mpmp_pkg::burst_count_t can_pop    // largest pop taken right now
);
    import mpmp_pkg::*;

    // write side control
    logic         write_accept;
    burst_count_t write_accept_count;
    bank_mask_t   write_mask;
    bank_ptr_t    write_ptr;
    logic         write_landed;       // burst has reached the banks
    burst_count_t write_landed_count;

    // read side control
    logic         read_accept;
    burst_count_t read_accept_count;
    bank_mask_t   read_mask;
    bank_ptr_t    read_ptr;
    logic         read_landed;        // burst has left the banks, space is free again
    burst_count_t read_landed_count;

    // data toward and from the banks, lane i belongs to bank i here
    lane_data_t bank_wdata;
    lane_data_t bank_rdata;

    // the write tracker counts free words and starts full of space
    mpmp_occupancy_tracker #(
        .RESET_WORDS (occupancy_t'(FIFO_DEPTH))
    ) write_tracker (
        .clk          (clk),
        .reset_n      (reset_n),
        .request      (push),
        .landed       (read_landed),
        .landed_count (read_landed_count),
        .accept       (write_accept),
        .accept_count (write_accept_count),
        .limit        (can_push)
    );

    // the read tracker counts stored words and starts empty
    mpmp_occupancy_tracker #(
        .RESET_WORDS ('0)
    ) read_tracker (
        .clk          (clk),
        .reset_n      (reset_n),
        .request      (pop),
        .landed       (write_landed),
        .landed_count (write_landed_count),
        .accept       (read_accept),
        .accept_count (read_accept_count),
        .limit        (can_pop)
    );

    mpmp_bank_steer write_steer (
        .clk          (clk),
        .reset_n      (reset_n),
        .accept       (write_accept),
        .accept_count (write_accept_count),
        .bank_mask    (write_mask),
        .ptr          (write_ptr),
        .landed       (write_landed),
        .landed_count (write_landed_count)
    );

    mpmp_bank_steer read_steer (
        .clk          (clk),
        .reset_n      (reset_n),
        .accept       (read_accept),
        .accept_count (read_accept_count),
        .bank_mask    (read_mask),
        .ptr          (read_ptr),
        .landed       (read_landed),
        .landed_count (read_landed_count)
    );

    mpmp_write_aligner write_aligner (
        .clk        (clk),
        .push_data  (push_data),
        .ptr        (write_ptr),
        .bank_wdata (bank_wdata)
    );

    // one narrow bank per lane, each with its own wrapping addresses
    for (genvar i = 0; i < MAX_BURST; i++) begin : gen_bank
        mpmp_ram_bank bank (
            .clk     (clk),
            .reset_n (reset_n),
            .write   (write_mask[i]),
            .wdata   (bank_wdata[i]),
            .read    (read_mask[i]),
            .rdata   (bank_rdata[i])
        );
    end

    mpmp_read_aligner read_aligner (
        .clk        (clk),
        .reset_n    (reset_n),
        .bank_rdata (bank_rdata),
        .ptr        (read_ptr),
        .count      (read_landed_count),
        .pop_data   (pop_data),
        .pop_resp   (pop_resp)
    );

endmodule

/* verification/mpmp_tb_tasks.svh */
// directed tests of the multi-push multi-pop FIFO, included inside the testbench module
`ifndef MPMP_TB_TASKS_SVH
`define MPMP_TB_TASKS_SVH

// limits are zero in reset and open up one edge after release
task automatic reset_values();
    @(negedge clk);  // one rising edge has passed with reset_n low
    check_value("can_push", 0, can_push);
    check_value("can_pop", 0, can_pop);
    check_value("pop_resp", 0, pop_resp);
    @(negedge clk);
    reset_n = 1'b1;  // released after two full periods
    @(negedge clk);
    check_value("can_push", (FIFO_DEPTH < MAX_BURST) ? FIFO_DEPTH : MAX_BURST, can_push);
    check_value("can_pop", 0, can_pop);
endtask

task automatic single_words_in_order();
    for (int i = 0; i < 5; i++) begin
        drive_cycle(1, 0);
    end
    for (int i = 0; i < 5; i++) begin
        wait_until_ready(0, 1);  // the first pop waits for the first word to land
        drive_cycle(0, 1);
    end
    wait_for_drain();
endtask

// the bank pointers start mid-array here, so these bursts wrap around bank 0
task automatic bursts_across_banks();
    int push_sizes[4] = '{5, 7, 3, 4};
    int pop_sizes[3]  = '{6, 9, 4};
    wait_until_ready(MAX_BURST, 0);
    foreach (push_sizes[i]) begin
        wait_until_ready(push_sizes[i], 0);
        drive_cycle(push_sizes[i], 0);
    end
    foreach (pop_sizes[i]) begin
        wait_until_ready(0, pop_sizes[i]);
        drive_cycle(0, pop_sizes[i]);
    end
    wait_for_drain();
    // the last pop gave its space back two cycles before its response came out
    check_value("can_push", MAX_BURST, can_push);
endtask

task automatic oversize_requests();
    wait_until_ready(MAX_BURST, 0);
    drive_cycle(10, 0);
    check_value("can_push", FIFO_DEPTH - 10, can_push);
    drive_cycle(12, 0);                  // asks for more than the 9 free words and is dropped whole
    check_value("can_push", FIFO_DEPTH - 10, can_push);
    wait_until_ready(0, 10);
    repeat (4) begin
        drive_cycle(0, 0);
    end
    check_value("can_pop", 10, can_pop); // the dropped burst never shows up
    check_value("can_push", FIFO_DEPTH - 10, can_push);
    drive_cycle(0, 11);                  // one word too many, so no response follows
    check_value("can_pop", 10, can_pop);
    drive_cycle(0, 4);
    drive_cycle(0, 6);
    wait_for_drain();
endtask

// four pops in a row must come back in four consecutive cycles
task automatic back_to_back_pops();
    wait_until_ready(MAX_BURST, 0);
    drive_cycle(MAX_BURST, 0);
    wait_until_ready(0, MAX_BURST);
    drive_cycle(0, 2);
    drive_cycle(0, 3);
    drive_cycle(0, 4);
    drive_cycle(0, 4);
    check_value("can_pop", 0, can_pop);  // all thirteen words were taken
    wait_for_drain();
endtask

task automatic random_mix();
    int push_n;
    int pop_n;
    for (int i = 0; i < 300; i++) begin
        push_n = $urandom_range(int'(can_push));  // always within the current limits
        pop_n  = $urandom_range(int'(can_pop));
        drive_cycle(push_n, pop_n);
    end
    wait_for_drain();
endtask

`endif

/* verification/multi_push_multi_pop_fifo_tb.sv */
// testbench top with clock, reset, watchdog, queue model, response monitor and test sequence
`timescale 1ns/1ps

module multi_push_multi_pop_fifo_tb;
    import mpmp_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_TESTS  = 6;
    // a request driven after edge n is sampled at edge n+1 and answered after edge n+7
    localparam int RESP_DELAY = 7;

    logic         clk = 1'b0;
    logic         reset_n;
    burst_count_t push;
    lane_data_t   push_data;
    burst_count_t can_push;
    burst_count_t pop;
    lane_data_t   pop_data;
    burst_count_t pop_resp;
    burst_count_t can_pop;

    data_word_t model_q[$];    // words accepted by the FIFO and not yet popped, oldest first
    data_word_t exp_words[$];  // words of the outstanding responses, in response order
    int         exp_counts[$]; // word count of each outstanding response
    int         exp_due[$];    // cycle in which each response has to show up
    int         cycle = 0;     // counts rising edges since time zero
    int         value_errors = 0;
    int         other_errors = 0;

    multi_push_multi_pop_fifo dut0 (
        .clk       (clk),
        .reset_n   (reset_n),
        .push      (push),
        .push_data (push_data),
        .can_push  (can_push),
        .pop       (pop),
        .pop_data  (pop_data),
        .pop_resp  (pop_resp),
        .can_pop   (can_pop)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] expected,
                               input logic [DATA_WIDTH-1:0] actual);
        assert (actual === expected) else begin
            value_errors++;
            $display("FAILED %s expected 0x%0h got 0x%0h at %0t ns", name, expected, actual, $time);
        end
    endtask

    task automatic report_problem(input string msg);
        other_errors++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    // forget the oldest outstanding response together with its words
    task automatic drop_expected();
        for (int i = 0; i < exp_counts[0]; i++) begin
            void'(exp_words.pop_front());
        end
        void'(exp_counts.pop_front());
        void'(exp_due.pop_front());
    endtask

    task automatic print_error_counts();
        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    endtask

    // drives one request at a falling edge and returns at the next falling edge
    task automatic drive_cycle(input int push_n, input int pop_n);
        lane_data_t data;
        for (int i = 0; i < MAX_BURST; i++) begin
            data[i] = $urandom();  // unused lanes carry noise as well
        end
        push      = burst_count_t'(push_n);
        push_data = data;
        pop       = burst_count_t'(pop_n);
        // a pop only reaches words stored before this cycle, so it is modelled first
        if (pop_n > 0 && pop_n <= int'(can_pop) && pop_n <= model_q.size()) begin
            for (int i = 0; i < pop_n; i++) begin
                exp_words.push_back(model_q.pop_front());
            end
            exp_counts.push_back(pop_n);
            exp_due.push_back(cycle + RESP_DELAY);
        end
        if (push_n > 0 && push_n <= int'(can_push)) begin  // taken whole, else dropped whole
            for (int i = 0; i < push_n; i++) begin
                model_q.push_back(data[i]);
            end
        end
        @(negedge clk);
    endtask

    // idles until both limits allow the wanted burst sizes
    task automatic wait_until_ready(input int push_n, input int pop_n);
        int waited = 0;
        while ((int'(can_push) < push_n || int'(can_pop) < pop_n) && waited < 30) begin
            drive_cycle(0, 0);
            waited++;
        end
        assert (waited < 30) else
            report_problem($sformatf("limits never reached push %0d and pop %0d", push_n, pop_n));
    endtask

    // idles until every accepted pop has been answered
    task automatic wait_for_drain();
        int waited = 0;
        drive_cycle(0, 0);
        while (exp_counts.size() > 0 && waited < 20) begin
            drive_cycle(0, 0);
            waited++;
        end
        assert (exp_counts.size() == 0) else
            report_problem($sformatf("%0d pop responses still outstanding", exp_counts.size()));
    endtask

    `include "mpmp_tb_tasks.svh"

    // samples a quarter period after the rising edge, well clear of the falling-edge drive
    always @(posedge clk) begin
        #(CLK_PERIOD / 4);
        if (exp_due.size() > 0) begin
            assert (exp_due[0] >= cycle) else begin
                report_problem($sformatf("no pop_resp for a pop of %0d words due in cycle %0d",
                                         exp_counts[0], exp_due[0]));
                drop_expected();
            end
        end
        if (pop_resp != '0) begin
            assert (exp_counts.size() > 0) else
                report_problem($sformatf("pop_resp of %0d with no pop outstanding", pop_resp));
            if (exp_counts.size() > 0) begin
                check_value("pop_resp", exp_counts[0], pop_resp);
                assert (exp_due[0] == cycle) else
                    report_problem($sformatf("response came in cycle %0d instead of %0d",
                                             cycle, exp_due[0]));
                for (int i = 0; i < exp_counts[0]; i++) begin
                    check_value($sformatf("pop_data[%0d]", i), exp_words[i], pop_data[i]);
                end
                drop_expected();
            end
        end
        if (reset_n === 1'b1) begin
            // can_pop lags pushes, can_push lags pops, so neither may run ahead of the model
            assert (int'(can_pop) <= model_q.size()) else
                report_problem($sformatf("can_pop %0d exceeds the %0d stored words",
                                         can_pop, model_q.size()));
            assert (int'(can_push) + model_q.size() <= FIFO_DEPTH) else
                report_problem($sformatf("can_push %0d overruns the FIFO depth", can_push));
        end
    end

    // the whole run is bounded by a budget of cycles per test
    initial begin
        #(NUM_TESTS * 400 * CLK_PERIOD);
        report_problem("watchdog expired before the tests finished");
        print_error_counts();
        $display("Test FAILED");
        $finish;
    end

    initial begin
        void'($urandom(17));
        reset_n   = 1'b0;
        push      = '0;
        push_data = '0;
        pop       = '0;
        reset_values();
        single_words_in_order();
        bursts_across_banks();
        oversize_requests();
        back_to_back_pops();
        random_mix();
        print_error_counts();
        if (value_errors + other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* multi_push_multi_pop_fifo.f */
+incdir+verification
hw/mpmp_pkg.sv
hw/mpmp_occupancy_tracker.sv
hw/mpmp_bank_steer.sv
hw/mpmp_write_aligner.sv
hw/mpmp_ram_bank.sv
hw/mpmp_read_aligner.sv
hw/multi_push_multi_pop_fifo.sv
verification/multi_push_multi_pop_fifo_tb.sv
